// ==== vlog.f ====
source/ps2_aux_pkg.sv
source/ps2_frame_rx.sv
source/aux_byte_fifo.sv
source/kbc_aux_regs.sv
source/ps2_aux_top.sv
tests/tb_ps2_aux_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PS/2 aux controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tb_ps2_aux_top -f vlog.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ps2_aux_top > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0

// ==== tests/tb_ps2_aux_top.sv ====
/*
 * Testbench for the PS/2 aux controller with random mouse bytes checked against a queue model.
 * Frames are sent one after another, so each byte reaches obf or the FIFO in turn.
 * The model capacity is FIFO_DEPTH plus the output buffer.
 */
module tb_ps2_aux_top import ps2_aux_pkg::*; ();

    localparam int FIFO_DEPTH = 16;
    localparam int WAIT_LIMIT = 400;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] io_address;
    logic       io_read;
    logic       io_write;
    logic [7:0] io_writedata;
    logic [7:0] io_readdata;
    logic [7:0] aux_cmd;
    logic       aux_cmd_valid;
    logic       irq_aux;

    // Reference model of accepted bytes in order and the config byte
    integer     seed;
    logic [7:0] model_q[$];
    logic [7:0] model_cfg;

    ps2_aux_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] status_byte(input logic perr, input logic mobf,
                                               input logic obf);
        return {perr, 1'b0, mobf, 4'b0000, obf};
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        @(negedge clk);
        io_write = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
        @(negedge clk);
        io_address = addr;
        io_read    = 1'b1;
        #10;
        data = io_readdata;
        @(negedge clk);
        io_read = 1'b0;
    endtask

    // Strobed status port read, irq_aux sampled in the same cycle
    task automatic read_status(output logic [7:0] st, output logic irq);
        @(negedge clk);
        io_address = port_cmd;
        io_read    = 1'b1;
        #10;
        st  = io_readdata;
        irq = irq_aux;
        @(negedge clk);
        io_read = 1'b0;
    endtask

    // Six clk per half period with data changing while ps2_clk is high
    task automatic send_frame(input logic [7:0] data, input logic corrupt);
        logic [10:0] bits;
        int          b;
        bits = {1'b1, (~^data) ^ corrupt, data, 1'b0};
        @(negedge clk);
        for (b = 0; b < 11; b++) begin
            ps2_data = bits[b];
            repeat (6) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (6) @(negedge clk);
            ps2_clk = 1'b1;
        end
        repeat (6) @(negedge clk);
        if (!corrupt && !model_cfg[cfg_aux_dis] && model_q.size() < FIFO_DEPTH + 1) begin
            model_q.push_back(data);
        end
    endtask

    task automatic wait_obf(input string name);
        logic [7:0] st;
        logic       irq;
        int         i;
        i = 0;
        read_status(st, irq);
        while (!st[0]) begin
            if (i == WAIT_LIMIT) stop_on_timeout($sformatf("obf in %s", name));
            read_status(st, irq);
            i++;
        end
    endtask

    task automatic drain_and_check(input string name);
        logic [7:0] st;
        logic [7:0] data;
        logic [7:0] expected;
        logic       irq;
        while (model_q.size() > 0) begin
            expected = model_q.pop_front();
            wait_obf(name);
            read_status(st, irq);
            check_value($sformatf("%s status", name), status_byte(1'b0, 1'b1, 1'b1), st);
            check_value($sformatf("%s irq_aux", name), {7'd0, model_cfg[cfg_aux_int]},
                        {7'd0, irq});
            bus_read(port_data, data);
            check_value($sformatf("%s data", name), expected, data);
        end
        repeat (8) @(negedge clk);
        read_status(st, irq);
        check_value($sformatf("%s empty", name), 8'h00, st);
    endtask

    // Command reply lands in obf with mobf clear and no interrupt
    task automatic check_reply(input string name, input logic [7:0] cmd,
                               input logic [7:0] expected);
        logic [7:0] st;
        logic [7:0] data;
        logic       irq;
        bus_write(port_cmd, cmd);
        wait_obf(name);
        read_status(st, irq);
        check_value($sformatf("%s status", name), status_byte(1'b0, 1'b0, 1'b1), st);
        check_value($sformatf("%s irq_aux", name), 8'h00, {7'd0, irq});
        bus_read(port_data, data);
        check_value(name, expected, data);
        read_status(st, irq);
        check_value($sformatf("%s after read", name), 8'h00, st);
    endtask

    initial begin : main
        logic [31:0] rnd;
        logic [7:0]  st;
        logic        irq;
        int          sent;
        int          burst;
        int          i;
        int          k;

        seed         = 99;
        model_cfg    = config_reset;
        rst_n        = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        io_address   = 8'h00;
        io_read      = 1'b0;
        io_write     = 1'b0;
        io_writedata = 8'h00;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Reset state and self test replies
        read_status(st, irq);
        check_value("reset status", 8'h00, st);
        check_value("reset irq_aux", 8'h00, {7'd0, irq});
        check_value("reset aux_cmd_valid", 8'h00, {7'd0, aux_cmd_valid});
        check_reply("read config", cmd_read_config, config_reset);
        check_reply("self test", cmd_self_test, self_test_ok);
        check_reply("aux test", cmd_test_aux, aux_test_ok);

        // Random bursts of mouse bytes
        sent = 0;
        while (sent < 40) begin
            rnd   = $random(seed);
            burst = rnd[1:0] + 1;
            if (burst > 40 - sent) burst = 40 - sent;
            for (k = 0; k < burst; k++) begin
                rnd = $random(seed);
                send_frame(rnd[7:0], 1'b0);
            end
            sent += burst;
            drain_and_check("random bytes");
        end

        // Disable drops frames and enable resumes delivery
        bus_write(port_cmd, cmd_disable_aux);
        model_cfg[cfg_aux_dis] = 1'b1;
        for (k = 0; k < 3; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b0);
        end
        read_status(st, irq);
        check_value("disabled status", 8'h00, st);
        check_reply("config after disable", cmd_read_config, model_cfg);
        bus_write(port_cmd, cmd_enable_aux);
        model_cfg[cfg_aux_dis] = 1'b0;
        for (k = 0; k < 3; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b0);
        end
        drain_and_check("enabled");

        // Bytes still arrive with the interrupt bit off
        bus_write(port_cmd, cmd_write_config);
        bus_write(port_data, 8'h01);
        model_cfg = 8'h01;
        for (k = 0; k < 3; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b0);
        end
        drain_and_check("no interrupt");
        bus_write(port_cmd, cmd_write_config);
        bus_write(port_data, config_reset);
        model_cfg = config_reset;

        // Write to aux gives exactly one strobe
        rnd = $random(seed);
        bus_write(port_cmd, cmd_write_aux);
        bus_write(port_data, rnd[7:0]);
        i = 0;
        while (!aux_cmd_valid) begin
            if (i == WAIT_LIMIT) stop_on_timeout("aux_cmd_valid");
            @(negedge clk);
            i++;
        end
        check_value("write aux byte", rnd[7:0], aux_cmd);
        @(negedge clk);
        check_value("write aux pulse width", 8'h00, {7'd0, aux_cmd_valid});
        bus_write(port_data, 8'h5A);
        for (k = 0; k < 10; k++) begin
            check_value("data write without command", 8'h00, {7'd0, aux_cmd_valid});
            @(negedge clk);
        end

        // Bad parity sets bit 7 and the next good frame clears it
        rnd = $random(seed);
        send_frame(rnd[7:0], 1'b1);
        read_status(st, irq);
        check_value("parity error status", status_byte(1'b1, 1'b0, 1'b0), st);
        rnd = $random(seed);
        send_frame(rnd[7:0], 1'b0);
        drain_and_check("after parity error");

        // Overflow keeps obf plus a full FIFO
        for (k = 0; k < FIFO_DEPTH + 3; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b0);
        end
        drain_and_check("overflow");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== source/ps2_aux_top.sv ====
/*
 * PS/2 aux port controller: frame receiver, byte FIFO, 8042-style registers.
 * FIFO_DEPTH must be a power of two. Receive only, no transmitter.
 */
module ps2_aux_top import ps2_aux_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic [7:0] io_address,
    input  logic       io_read,
    input  logic       io_write,
    input  logic [7:0] io_writedata,
    output logic [7:0] io_readdata,
    output logic [7:0] aux_cmd,
    output logic       aux_cmd_valid,
    output logic       irq_aux
);

    ps2_byte_t  rx_byte;
    logic [7:0] fifo_data;
    logic       fifo_empty;
    logic       fifo_full;
    logic       fifo_push;
    logic       fifo_pop;

    ps2_frame_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte)
    );

    aux_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_push),
        .wr_data (rx_byte.data),
        .rd_en   (fifo_pop),
        .rd_data (fifo_data),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    // Enable state already feeds fifo_push inside the register block
    kbc_aux_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .io_address    (io_address),
        .io_read       (io_read),
        .io_write      (io_write),
        .io_writedata  (io_writedata),
        .io_readdata   (io_readdata),
        .rx_byte       (rx_byte),
        .fifo_data     (fifo_data),
        .fifo_empty    (fifo_empty),
        .full          (fifo_full),
        .fifo_pop      (fifo_pop),
        .fifo_push     (fifo_push),
        .aux_enable    (),
        .aux_cmd       (aux_cmd),
        .aux_cmd_valid (aux_cmd_valid),
        .irq_aux       (irq_aux)
    );

endmodule

// ==== source/kbc_aux_regs.sv ====
/*
 * 8042-style register block for the aux (mouse) channel.
 * Data port and status/command port on a strobed CPU byte bus, read data
 * is combinational. No keyboard channel, no inhibit timeout, no A20 or
 * system flag; those status bits read as 0.
 */
module kbc_aux_regs import ps2_aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] io_address,
    input  logic       io_read,
    input  logic       io_write,
    input  logic [7:0] io_writedata,
    output logic [7:0] io_readdata,
    input  ps2_byte_t  rx_byte,
    input  logic [7:0] fifo_data,
    input  logic       fifo_empty,
    input  logic       full,
    output logic       fifo_pop,
    output logic       fifo_push,
    output logic       aux_enable,
    output logic [7:0] aux_cmd,
    output logic       aux_cmd_valid,
    output logic       irq_aux
);

    logic [7:0]  config_byte;
    logic [7:0]  out_buf;
    logic        obf;
    logic        from_aux;
    logic        perr;
    logic        pending;
    logic [7:0]  pending_cmd;
    kbc_status_t status;

    // Decoded bus strobes
    logic data_rd;
    logic data_wr;
    logic cmd_wr;
    logic cmd_reply;

    assign data_rd = io_read && (io_address == port_data);
    assign data_wr = io_write && (io_address == port_data);
    assign cmd_wr  = io_write && (io_address == port_cmd);

    // Commands that place a reply in the output buffer
    assign cmd_reply = cmd_wr &&
                       (io_writedata inside {cmd_read_config, cmd_test_aux, cmd_self_test});

    assign aux_enable = !config_byte[cfg_aux_dis];
    assign fifo_push  = rx_byte.valid && !rx_byte.parity_err && !full && aux_enable;

    // A reply written this cycle takes the buffer ahead of the FIFO
    assign fifo_pop = !obf && !fifo_empty && !cmd_reply;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            config_byte   <= config_reset;
            obf           <= 1'b0;
            from_aux      <= 1'b0;
            perr          <= 1'b0;
            pending       <= 1'b0;
            pending_cmd   <= 8'h00;
            aux_cmd_valid <= 1'b0;
        end else begin
            aux_cmd_valid <= 1'b0;

            // Last frame decides the parity error flag
            if (rx_byte.valid) begin
                perr <= rx_byte.parity_err;
            end

            if (data_rd) begin
                obf      <= 1'b0;
                from_aux <= 1'b0;
            end

            if (fifo_pop) begin
                obf      <= 1'b1;
                from_aux <= 1'b1;
            end

            // Parameter byte for a pending command
            if (data_wr && pending) begin
                pending <= 1'b0;
                case (pending_cmd)
                    cmd_write_config: config_byte <= io_writedata;
                    cmd_write_aux:    aux_cmd_valid <= 1'b1;
                    default: ;
                endcase
            end

            if (cmd_wr) begin
                // Any new command cancels an unused parameter wait
                pending <= 1'b0;
                case (io_writedata)
                    cmd_write_config, cmd_write_aux: begin
                        pending     <= 1'b1;
                        pending_cmd <= io_writedata;
                    end
                    cmd_disable_aux: config_byte[cfg_aux_dis] <= 1'b1;
                    cmd_enable_aux:  config_byte[cfg_aux_dis] <= 1'b0;
                    default: ;
                endcase
                if (cmd_reply) begin
                    obf      <= 1'b1;
                    from_aux <= 1'b0;
                end
            end
        end
    end

    // Output buffer contents
    always_ff @(posedge clk) begin
        if (cmd_reply) begin
            case (io_writedata)
                cmd_read_config: out_buf <= config_byte;
                cmd_self_test:   out_buf <= self_test_ok;
                default:         out_buf <= aux_test_ok;
            endcase
        end else if (fifo_pop) begin
            out_buf <= fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr && pending && pending_cmd == cmd_write_aux) begin
            aux_cmd <= io_writedata;
        end
    end

    always_comb begin
        status            = '0;
        status.obf        = obf;
        status.mobf       = from_aux;
        status.parity_err = perr;
    end

    always_comb begin
        case (io_address)
            port_data: io_readdata = out_buf;
            port_cmd:  io_readdata = status;
            default:   io_readdata = 8'h00;
        endcase
    end

    // IRQ12 equivalent
    assign irq_aux = obf && from_aux && config_byte[cfg_aux_int];

endmodule

// ==== source/aux_byte_fifo.sv ====
/*
 * Byte FIFO with show-ahead read data.
 * FIFO_DEPTH must be a power of two. Writes while full and reads while
 * empty are ignored.
 */
module aux_byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]  mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == (AW+1)'(FIFO_DEPTH));

endmodule

// ==== source/ps2_frame_rx.sv ====
/*
 * PS/2 device-to-host frame receiver.
 * ps2_clk and ps2_data are asynchronous and go through two-flop synchronizers,
 * so clk must run well above the PS/2 bit rate. No inhibit or frame timeout:
 * a frame cut short leaves the receiver waiting for the remaining bits.
 */
module ps2_frame_rx import ps2_aux_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    output ps2_byte_t rx_byte
);

    // Synchronizer stages and edge history
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;

    // Frame state
    logic [3:0] bit_cnt;
    logic [8:0] shift;

    // Output byte, valid is the only control bit
    logic       out_valid;
    logic [7:0] out_data;
    logic       out_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    // Bit counter: 0 waits for start, 1..9 take data and parity, 10 is stop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= 4'd0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd0) begin
                    // A high start bit is line noise
                    if (!data_sync[1]) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt   <= 4'd0;
                    out_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Data bits arrive LSB first and shift down toward bit 0
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            if (bit_cnt != 4'd0 && bit_cnt != 4'd10) begin
                shift <= {data_sync[1], shift[8:1]};
            end
            if (bit_cnt == 4'd10) begin
                out_data <= shift[7:0];
                // Odd parity over data and parity bit, stop bit must be 1
                out_err  <= !(^shift) || !data_sync[1];
            end
        end
    end

    assign rx_byte = '{data: out_data, valid: out_valid, parity_err: out_err};

endmodule

// ==== source/ps2_aux_pkg.sv ====
/*
 * Shared types and constants for the 8042-style PS/2 aux port controller.
 * Status register layout follows the classic 8042 bit order, obf at bit 0.
 * Only the aux channel commands listed here are decoded.
 */
package ps2_aux_pkg;

    // One received PS/2 frame, parity_err also covers a bad stop bit
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       parity_err;
    } ps2_byte_t;

    // 8042 status byte, MSB first
    typedef struct packed {
        logic parity_err;
        logic timeout;
        logic mobf;
        logic inh;
        logic a2;
        logic sys;
        logic ibf;
        logic obf;
    } kbc_status_t;

    // Controller commands written to the command port
    localparam logic [7:0] cmd_read_config  = 8'h20;
    localparam logic [7:0] cmd_write_config = 8'h60;
    localparam logic [7:0] cmd_disable_aux  = 8'hA7;
    localparam logic [7:0] cmd_enable_aux   = 8'hA8;
    localparam logic [7:0] cmd_test_aux     = 8'hA9;
    localparam logic [7:0] cmd_self_test    = 8'hAA;
    localparam logic [7:0] cmd_write_aux    = 8'hD4;

    // Config byte bits
    localparam int cfg_aux_int = 1;
    localparam int cfg_aux_dis = 5;

    // CPU port addresses
    localparam logic [7:0] port_data = 8'h00;
    localparam logic [7:0] port_cmd  = 8'h04;

    // Replies and reset values
    localparam logic [7:0] config_reset = 8'h03;
    localparam logic [7:0] self_test_ok = 8'h55;
    localparam logic [7:0] aux_test_ok  = 8'h00;

endpackage
